// ==== source/tcb_pkg.sv ====
/*
  tcb bus package
  widths, transfer size codes and the request and response
  structs of the tightly coupled bus
*/

`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////////////

  // address width
  localparam int tcb_abw = 32;
  // data width
  localparam int tcb_dbw = 32;

  //////////////////////////////////////////////////////////////////////
  // transfer size
  //////////////////////////////////////////////////////////////////////

  // log2 of the byte count, as in risc-v func3[1:0]
  typedef enum logic [1:0] {
    tcb_siz_byte = 2'b00,
    tcb_siz_half = 2'b01,
    tcb_siz_word = 2'b10
  } tcb_siz_t;

  //////////////////////////////////////////////////////////////////////
  // request and response
  //////////////////////////////////////////////////////////////////////

  // request, 68 bits
  typedef struct packed {
    logic               wen;  // write enable
    logic [tcb_abw-1:0] adr;  // address
    tcb_siz_t           siz;  // size code
    logic               uns;  // unsigned load
    logic [tcb_dbw-1:0] wdt;  // write data
  } tcb_req_t;

  // response, one cycle after the request
  typedef struct packed {
    logic [tcb_dbw-1:0] rdt;  // read data
    logic               err;  // bus error
  } tcb_rsp_t;

endpackage

`default_nettype wire

// ==== source/trace_pkg.sv ====
/*
  trace package
  execution phase codes, completed transfer, retirement record,
  error event and the sizing of the trace unit
*/

`default_nettype none

package trace_pkg;

  //////////////////////////////////////////////////////////////////////
  // execution phases
  //////////////////////////////////////////////////////////////////////

  // register access phases share bit 2 with write-back
  typedef enum logic [2:0] {
    pha_if  = 3'b000,  // instruction fetch
    pha_mld = 3'b001,  // memory load
    pha_mst = 3'b010,  // memory store
    pha_exe = 3'b011,  // execute, branch condition only
    pha_wb  = 3'b100,  // register write-back
    pha_rs1 = 3'b101,  // register source 1 read
    pha_rs2 = 3'b110   // register source 2 read
  } pha_t;

  //////////////////////////////////////////////////////////////////////
  // sizing
  //////////////////////////////////////////////////////////////////////

  localparam int rec_depth  = 8;
  localparam int evt_depth  = 4;
  // quiet cycles before the watchdog flushes
  localparam int idle_limit = 16;
  localparam int idle_w     = $clog2(idle_limit + 1);
  // cycle stamp width
  localparam int tim_w      = 32;

  //////////////////////////////////////////////////////////////////////
  // transfer, record, event
  //////////////////////////////////////////////////////////////////////

  // request joined with its response
  typedef struct packed {
    pha_t                           pha;
    logic                           wen;
    logic [tcb_pkg::tcb_abw-1:0]    adr;
    tcb_pkg::tcb_siz_t              siz;
    logic [tcb_pkg::tcb_dbw-1:0]    dat;  // wdt on writes, rdt on reads
    logic                           err;
  } xfer_t;

  // one retired instruction
  typedef struct packed {
    logic [tcb_pkg::tcb_abw-1:0] pc;
    logic [tcb_pkg::tcb_dbw-1:0] ins;
    logic                        wb_vld;
    logic [4:0]                  wb_rd;
    logic [tcb_pkg::tcb_dbw-1:0] wb_dat;
    logic                        ld_vld;
    logic [tcb_pkg::tcb_abw-1:0] ld_adr;
    logic                        st_vld;
    logic [tcb_pkg::tcb_abw-1:0] st_adr;
    logic [tcb_pkg::tcb_dbw-1:0] st_dat;
    logic                        err;  // bus error inside the instruction
    logic                        stl;  // closed by watchdog
    logic [tim_w-1:0]            tim;  // stamp of the fetch
  } rec_t;

  typedef enum logic [1:0] {
    evt_bus_err = 2'd0,
    evt_seq_err = 2'd1,
    evt_dup_mem = 2'd2
  } evt_kind_t;

  typedef struct packed {
    evt_kind_t                   kind;
    pha_t                        pha;
    logic [tcb_pkg::tcb_abw-1:0] adr;
    logic [tim_w-1:0]            tim;
  } evt_t;

endpackage

`default_nettype wire

// ==== source/tcb_xfer_capture.sv ====
/*
  tcb transfer capture
  registers each accepted request with its phase and joins it with
  the response of the following cycle into one completed transfer
*/

`timescale 1ns/1ps
`default_nettype none

module tcb_xfer_capture (
  input  logic                tcb,
  input  logic                arst_n,
  // observed bus
  input  logic                tcb_vld,
  input  logic                tcb_rdy,
  input  tcb_pkg::tcb_req_t   tcb_req,
  input  tcb_pkg::tcb_rsp_t   tcb_rsp,
  input  trace_pkg::pha_t     pha,
  // completed transfer
  output logic                xfer_vld,
  output trace_pkg::xfer_t    xfer
);

  //////////////////////////////////////////////////////////////////////
  // request stage
  //////////////////////////////////////////////////////////////////////

  // handshake on this edge
  logic trn;
  // transfer waiting for its response
  logic trn_q;

  tcb_pkg::tcb_req_t req_q;
  trace_pkg::pha_t   pha_q;

  assign trn = tcb_vld && tcb_rdy;

  // pipeline valids
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      trn_q    <= 1'b0;
      xfer_vld <= 1'b0;
    end else begin
      trn_q    <= trn;
      xfer_vld <= trn_q;
    end
  end

  // request and phase held for one cycle
  always_ff @(posedge tcb) begin
    if (trn) begin
      req_q <= tcb_req;
      pha_q <= pha;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response stage
  //////////////////////////////////////////////////////////////////////

  // response belongs to the request of the previous edge
  always_ff @(posedge tcb) begin
    if (trn_q) begin
      xfer.pha <= pha_q;
      xfer.wen <= req_q.wen;
      xfer.adr <= req_q.adr;
      xfer.siz <= req_q.siz;
      // write data for stores, read data otherwise
      xfer.dat <= req_q.wen ? req_q.wdt : tcb_rsp.rdt;
      xfer.err <= tcb_rsp.err;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus checks
  //////////////////////////////////////////////////////////////////////

  // valid always defined once out of reset
  a_vld_known : assert property (
    @(posedge tcb) disable iff (!arst_n) !$isunknown(tcb_vld)
  );

  // request fields defined during a cycle
  a_req_known : assert property (
    @(posedge tcb) disable iff (!arst_n)
    tcb_vld |-> !$isunknown({tcb_rdy, tcb_req.wen, tcb_req.adr, tcb_req.siz, tcb_req.uns})
  );

endmodule

`default_nettype wire

// ==== source/trace_phase_fsm.sv ====
/*
  trace phase state machine
  groups completed transfers into retirement records and reports
  bus errors and illegal phase orders as events
*/

`timescale 1ns/1ps
`default_nettype none

module trace_phase_fsm (
  input  logic                          tcb,
  input  logic                          arst_n,
  input  logic                          xfer_vld,
  input  trace_pkg::xfer_t              xfer,
  input  logic [trace_pkg::tim_w-1:0]   tim,
  input  logic                          idle_expire,
  output logic                          rec_push,
  output trace_pkg::rec_t               rec,
  output logic                          evt_push,
  output trace_pkg::evt_t               evt,
  output logic                          retire
);

  typedef enum logic [1:0] {
    st_wait_first,  // reset jump not yet fetched
    st_wait_fetch,  // after watchdog flush
    st_collect
  } state_t;

  state_t state, state_nxt;

  // open record belongs to the reset jump
  logic skip, skip_nxt;

  trace_pkg::rec_t cur, cur_nxt;
  trace_pkg::rec_t rec_nxt;
  trace_pkg::evt_t evt_nxt;
  logic            rec_push_nxt;
  logic            evt_push_nxt;

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt    = state;
    skip_nxt     = skip;
    cur_nxt      = cur;
    rec_nxt      = cur;
    rec_push_nxt = 1'b0;
    evt_nxt      = '{kind: trace_pkg::evt_bus_err, pha: xfer.pha, adr: xfer.adr, tim: tim};
    evt_push_nxt = 1'b0;
    if (xfer_vld) begin
      if (xfer.pha == trace_pkg::pha_if) begin
        // fetch closes the open record
        rec_push_nxt = (state == st_collect) && !skip;
        skip_nxt     = (state == st_wait_first);
        state_nxt    = st_collect;
        cur_nxt      = '0;
        cur_nxt.pc   = xfer.adr;
        cur_nxt.ins  = xfer.dat;
        cur_nxt.tim  = tim;
      end else if (state != st_collect) begin
        // no instruction open
        evt_push_nxt = 1'b1;
        evt_nxt.kind = trace_pkg::evt_seq_err;
      end else begin
        case (xfer.pha)
          trace_pkg::pha_wb: begin
            // only word writes reach the register file
            if (xfer.wen && (xfer.siz == tcb_pkg::tcb_siz_word)) begin
              cur_nxt.wb_vld = 1'b1;
              cur_nxt.wb_rd  = xfer.adr[6:2];
              cur_nxt.wb_dat = xfer.dat;
            end
          end
          trace_pkg::pha_mld, trace_pkg::pha_mst: begin
            if (cur.ld_vld || cur.st_vld) begin
              // first access stays in the record
              evt_push_nxt = 1'b1;
              evt_nxt.kind = trace_pkg::evt_dup_mem;
            end else if (xfer.pha == trace_pkg::pha_mld) begin
              cur_nxt.ld_vld = 1'b1;
              cur_nxt.ld_adr = xfer.adr;
            end else begin
              cur_nxt.st_vld = 1'b1;
              cur_nxt.st_adr = xfer.adr;
              cur_nxt.st_dat = xfer.dat;
            end
          end
          // rs1, rs2, exe carry nothing for the record
          default: begin
          end
        endcase
      end
      // bus error overrides any order error
      if (xfer.err) begin
        cur_nxt.err  = 1'b1;
        evt_push_nxt = 1'b1;
        evt_nxt.kind = trace_pkg::evt_bus_err;
      end
    end else if (idle_expire && (state == st_collect)) begin
      // watchdog flush of a stalled instruction
      rec_push_nxt = !skip;
      rec_nxt.stl  = 1'b1;
      state_nxt    = st_wait_fetch;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_wait_first;
      skip     <= 1'b0;
      cur      <= '0;
      rec_push <= 1'b0;
      evt_push <= 1'b0;
    end else begin
      state    <= state_nxt;
      skip     <= skip_nxt;
      cur      <= cur_nxt;
      rec_push <= rec_push_nxt;
      evt_push <= evt_push_nxt;
    end
  end

  // outgoing record and event
  always_ff @(posedge tcb) begin
    rec <= rec_nxt;
    evt <= evt_nxt;
  end

  // one retirement per record
  assign retire = rec_push;

  // reset jump never produces a record
  a_no_rec_first : assert property (
    @(posedge tcb) disable iff (!arst_n) !(rec_push && (state == st_wait_first))
  );

endmodule

`default_nettype wire

// ==== source/trace_timer.sv ====
/*
  trace timer
  free running cycle stamp, idle watchdog and retirement counter
*/

`timescale 1ns/1ps
`default_nettype none

module trace_timer (
  input  logic                          tcb,
  input  logic                          arst_n,
  input  logic                          xfer_vld,
  input  logic                          retire,
  output logic [trace_pkg::tim_w-1:0]   tim,
  output logic                          idle_expire,
  output logic [trace_pkg::tim_w-1:0]   retire_cnt
);

  // quiet cycles since the last transfer, saturating
  logic [trace_pkg::idle_w-1:0] idle_cnt;

  //////////////////////////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      tim        <= '0;
      idle_cnt   <= '0;
      retire_cnt <= '0;
    end else begin
      tim <= tim + 1'b1;
      // any transfer rearms the watchdog
      if (xfer_vld) begin
        idle_cnt <= '0;
      end else if (idle_cnt != trace_pkg::idle_w'(trace_pkg::idle_limit)) begin
        idle_cnt <= idle_cnt + 1'b1;
      end
      if (retire) begin
        retire_cnt <= retire_cnt + 1'b1;
      end
    end
  end

  // fires in the last quiet cycle, then the count sits at the limit
  assign idle_expire = !xfer_vld &&
                       (idle_cnt == trace_pkg::idle_w'(trace_pkg::idle_limit - 1));

  // single cycle pulse
  a_expire_pulse : assert property (
    @(posedge tcb) disable iff (!arst_n) idle_expire |=> !idle_expire
  );

endmodule

`default_nettype wire

// ==== source/trace_fifo.sv ====
/*
  trace queue
  first word fall through circular buffer for any payload type,
  drops pushes when full and keeps a sticky overflow flag
*/

`timescale 1ns/1ps
`default_nettype none

module trace_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     tcb,
  input  logic     arst_n,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     overflow
);

  localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] cnt;
  logic             do_push;
  logic             do_pop;

  // pointer step with wrap for any depth
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty  = (cnt == '0);
  assign head   = mem[rd_ptr];
  assign do_pop = pop && !empty;
  // a pop in the same cycle frees the slot
  assign do_push = push && ((cnt != cnt_w'(DEPTH)) || do_pop);

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      cnt      <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
      if (do_push && !do_pop) begin
        cnt <= cnt + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt <= cnt - 1'b1;
      end
      // sticky until reset
      if (push && !do_push) overflow <= 1'b1;
    end
  end

  // storage
  always_ff @(posedge tcb) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  a_cnt_bound : assert property (
    @(posedge tcb) disable iff (!arst_n) cnt <= cnt_w'(DEPTH)
  );

endmodule

`default_nettype wire

// ==== source/tcb_trace_top.sv ====
/*
  tcb trace unit
  capture, phase state machine, timer, record queue and event queue
*/

`timescale 1ns/1ps
`default_nettype none

module tcb_trace_top (
  input  logic                          tcb,
  input  logic                          arst_n,
  // observed bus
  input  logic                          tcb_vld,
  input  logic                          tcb_rdy,
  input  tcb_pkg::tcb_req_t             tcb_req,
  input  tcb_pkg::tcb_rsp_t             tcb_rsp,
  input  trace_pkg::pha_t               pha,
  // reader
  input  logic                          rec_pop,
  input  logic                          evt_pop,
  output trace_pkg::rec_t               rec_head,
  output logic                          rec_empty,
  output logic                          rec_overflow,
  output trace_pkg::evt_t               evt_head,
  output logic                          evt_empty,
  output logic                          evt_overflow,
  output logic [trace_pkg::tim_w-1:0]   retire_cnt
);

  logic                        xfer_vld;
  trace_pkg::xfer_t            xfer;
  logic [trace_pkg::tim_w-1:0] tim;
  logic                        idle_expire;
  logic                        retire;
  logic                        rec_push;
  trace_pkg::rec_t             rec;
  logic                        evt_push;
  trace_pkg::evt_t             evt;

  //////////////////////////////////////////////////////////////////////
  // trace pipeline
  //////////////////////////////////////////////////////////////////////

  tcb_xfer_capture u_capture (
    .tcb      (tcb),      .arst_n   (arst_n),
    .tcb_vld  (tcb_vld),  .tcb_rdy  (tcb_rdy),
    .tcb_req  (tcb_req),  .tcb_rsp  (tcb_rsp),
    .pha      (pha),
    .xfer_vld (xfer_vld), .xfer     (xfer)
  );

  trace_phase_fsm u_fsm (
    .tcb         (tcb),         .arst_n   (arst_n),
    .xfer_vld    (xfer_vld),    .xfer     (xfer),
    .tim         (tim),         .idle_expire (idle_expire),
    .rec_push    (rec_push),    .rec      (rec),
    .evt_push    (evt_push),    .evt      (evt),
    .retire      (retire)
  );

  trace_timer u_timer (
    .tcb      (tcb),      .arst_n      (arst_n),
    .xfer_vld (xfer_vld), .retire      (retire),
    .tim      (tim),      .idle_expire (idle_expire),
    .retire_cnt (retire_cnt)
  );

  //////////////////////////////////////////////////////////////////////
  // queues
  //////////////////////////////////////////////////////////////////////

  trace_fifo #(.payload_t (trace_pkg::rec_t), .DEPTH (trace_pkg::rec_depth)) u_rec_fifo (
    .tcb  (tcb),      .arst_n (arst_n),
    .push (rec_push), .din    (rec),       .pop      (rec_pop),
    .head (rec_head), .empty  (rec_empty), .overflow (rec_overflow)
  );

  trace_fifo #(.payload_t (trace_pkg::evt_t), .DEPTH (trace_pkg::evt_depth)) u_evt_fifo (
    .tcb  (tcb),      .arst_n (arst_n),
    .push (evt_push), .din    (evt),       .pop      (evt_pop),
    .head (evt_head), .empty  (evt_empty), .overflow (evt_overflow)
  );

endmodule

`default_nettype wire

// ==== tb/tcb_trace_tb.sv ====
/*
  tcb trace unit testbench
  bus model driven from the stim file, drains both queues and
  compares records and events with the expected lines
*/

`timescale 1ns/1ps
`default_nettype none

module tcb_trace_tb;

  // cycles allowed for one queue entry to show up
  localparam int drain_wait = 40;

  logic                        tcb = 1'b0;
  logic                        arst_n;
  logic                        tcb_vld;
  logic                        tcb_rdy;
  tcb_pkg::tcb_req_t           tcb_req;
  tcb_pkg::tcb_rsp_t           tcb_rsp;
  trace_pkg::pha_t             pha;
  logic                        rec_pop;
  logic                        evt_pop;
  trace_pkg::rec_t             rec_head;
  logic                        rec_empty;
  logic                        rec_overflow;
  trace_pkg::evt_t             evt_head;
  logic                        evt_empty;
  logic                        evt_overflow;
  logic [trace_pkg::tim_w-1:0] retire_cnt;

  // stim lines and the expectations of the running test
  string           lines[$];
  trace_pkg::rec_t exp_rec[$];
  trace_pkg::evt_t exp_evt[$];
  string           test_name;
  int              test_err  = 0;
  int              tests     = 0;
  int              checks    = 0;
  int              errors    = 0;
  int              cyc       = 0;
  int              cyc_limit = 0;

  tcb_trace_top u_tcb_trace_top (
    .tcb          (tcb),
    .arst_n       (arst_n),
    .tcb_vld      (tcb_vld),
    .tcb_rdy      (tcb_rdy),
    .tcb_req      (tcb_req),
    .tcb_rsp      (tcb_rsp),
    .pha          (pha),
    .rec_pop      (rec_pop),
    .evt_pop      (evt_pop),
    .rec_head     (rec_head),
    .rec_empty    (rec_empty),
    .rec_overflow (rec_overflow),
    .evt_head     (evt_head),
    .evt_empty    (evt_empty),
    .evt_overflow (evt_overflow),
    .retire_cnt   (retire_cnt)
  );

  // 8 ns period
  always #4 tcb = ~tcb;

  // run limit from the stim length
  always @(posedge tcb) begin
    cyc = cyc + 1;
    if (cyc_limit > 0 && cyc > cyc_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cyc_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] want, input logic [31:0] act);
    checks++;
    if (want !== act) begin
      $display("FAIL %s %s: expected %h actual %h", test_name, what, want, act);
      errors++;
      test_err++;
    end
  endtask

  task automatic apply_reset();
    @(negedge tcb);
    arst_n = 1'b0;
    repeat (2) @(negedge tcb);
    arst_n = 1'b1;
  endtask

  // one transfer, optional ready stall, response one cycle later
  task automatic drive_xfer(input logic [2:0] p, input logic wen, input logic [31:0] adr,
                            input logic [1:0] siz, input logic [31:0] wdt,
                            input logic [31:0] rdt, input logic err, input int gap);
    int stall;
    stall = $urandom % 2;
    @(negedge tcb);
    tcb_vld = 1'b1;
    tcb_rdy = (stall == 0);
    tcb_req = '{wen: wen, adr: adr, siz: tcb_pkg::tcb_siz_t'(siz), uns: 1'b0, wdt: wdt};
    pha     = trace_pkg::pha_t'(p);
    tcb_rsp = '0;
    if (stall != 0) begin
      @(negedge tcb);
      tcb_rdy = 1'b1;
    end
    // handshake on the rising edge in between
    @(negedge tcb);
    tcb_vld     = 1'b0;
    tcb_rdy     = 1'b0;
    tcb_rsp.rdt = rdt;
    tcb_rsp.err = err;
    // short random gap, far below the idle limit
    repeat (gap + ($urandom % 2)) @(negedge tcb);
  endtask

  task automatic drain_records();
    int              n;
    bit              have_prev;
    logic [31:0]     prev_tim;
    trace_pkg::rec_t want;
    trace_pkg::rec_t got;
    have_prev = 1'b0;
    prev_tim  = '0;
    while (exp_rec.size() > 0) begin
      want = exp_rec.pop_front();
      n    = 0;
      while (rec_empty && n < drain_wait) begin
        @(negedge tcb);
        n++;
      end
      if (rec_empty) begin
        $display("test %s: record for pc %h never arrived", test_name, want.pc);
        errors++;
        test_err++;
      end else begin
        got = rec_head;
        check("pc", want.pc, got.pc);
        check("ins", want.ins, got.ins);
        check("wb_vld", want.wb_vld, got.wb_vld);
        check("wb_rd", want.wb_rd, got.wb_rd);
        check("wb_dat", want.wb_dat, got.wb_dat);
        check("ld_vld", want.ld_vld, got.ld_vld);
        check("ld_adr", want.ld_adr, got.ld_adr);
        check("st_vld", want.st_vld, got.st_vld);
        check("st_adr", want.st_adr, got.st_adr);
        check("st_dat", want.st_dat, got.st_dat);
        check("err", want.err, got.err);
        check("stl", want.stl, got.stl);
        // stamps of later fetches are larger
        if (have_prev) check("tim rising", 32'd1, {31'd0, got.tim > prev_tim});
        prev_tim  = got.tim;
        have_prev = 1'b1;
        rec_pop = 1'b1;
        @(negedge tcb);
        rec_pop = 1'b0;
      end
    end
    // longer than the push to empty latency
    repeat (4) @(negedge tcb);
    if (!rec_empty) begin
      $display("test %s: record queue holds more records than expected", test_name);
      errors++;
      test_err++;
    end
  endtask

  task automatic drain_events();
    int              n;
    bit              have_prev;
    logic [31:0]     prev_tim;
    trace_pkg::evt_t want;
    trace_pkg::evt_t got;
    have_prev = 1'b0;
    prev_tim  = '0;
    while (exp_evt.size() > 0) begin
      want = exp_evt.pop_front();
      n    = 0;
      while (evt_empty && n < drain_wait) begin
        @(negedge tcb);
        n++;
      end
      if (evt_empty) begin
        $display("test %s: event at address %h never arrived", test_name, want.adr);
        errors++;
        test_err++;
      end else begin
        got = evt_head;
        check("evt kind", want.kind, got.kind);
        check("evt pha", want.pha, got.pha);
        check("evt adr", want.adr, got.adr);
        // each event comes from its own transfer, later ones stamped larger
        if (have_prev) check("evt tim rising", 32'd1, {31'd0, got.tim > prev_tim});
        prev_tim  = got.tim;
        have_prev = 1'b1;
        evt_pop = 1'b1;
        @(negedge tcb);
        evt_pop = 1'b0;
      end
    end
    repeat (4) @(negedge tcb);
    if (!evt_empty) begin
      $display("test %s: event queue holds more events than expected", test_name);
      errors++;
      test_err++;
    end
  endtask

  // drain point, then a fresh reset for the next test
  task automatic finish_test(input string name, input logic [31:0] ret,
                             input logic rovf, input logic eovf);
    test_name = name;
    drain_records();
    drain_events();
    check("retire_cnt", ret, retire_cnt);
    check("rec_overflow", rovf, rec_overflow);
    check("evt_overflow", eovf, evt_overflow);
    $display("test %s: %0d errors", name, test_err);
    tests++;
    test_err = 0;
    apply_reset();
  endtask

  //////////////////////////////////////////////////////////////////////
  // stim file
  //////////////////////////////////////////////////////////////////////

  task automatic load_stim(output bit ok);
    int          fd;
    int          gap;
    logic [31:0] v [0:6];
    string       line;
    string       tag;
    ok        = 1'b0;
    cyc_limit = 10;
    fd        = $fopen("tb/tcb_trace_stim.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0 && $sscanf(line, "%s", tag) == 1 && tag.getc(0) != "#") begin
          lines.push_back(line);
          if (tag == "T") begin
            void'($sscanf(line, "T %h %h %h %h %h %h %h %d",
                          v[0], v[1], v[2], v[3], v[4], v[5], v[6], gap));
            // request, stall, response and random gap
            cyc_limit += gap + 6;
          end else if (tag == "C") begin
            // every queue entry may use its full wait, plus reset
            cyc_limit += (trace_pkg::rec_depth + trace_pkg::evt_depth) * (drain_wait + 2) + 16;
          end
        end
      end
      $fclose(fd);
      ok = 1'b1;
    end
  endtask

  task automatic run_line(input string line);
    string           tag;
    string           name;
    int              gap;
    logic [31:0]     v [0:11];
    trace_pkg::rec_t r;
    trace_pkg::evt_t e;
    void'($sscanf(line, "%s", tag));
    case (tag)
      "T": begin
        void'($sscanf(line, "T %h %h %h %h %h %h %h %d",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], gap));
        drive_xfer(v[0][2:0], v[1][0], v[2], v[3][1:0], v[4], v[5], v[6][0], gap);
      end
      "E": begin
        void'($sscanf(line, "E %h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                      v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]));
        r        = '0;
        r.pc     = v[0];
        r.ins    = v[1];
        r.wb_vld = v[2][0];
        r.wb_rd  = v[3][4:0];
        r.wb_dat = v[4];
        r.ld_vld = v[5][0];
        r.ld_adr = v[6];
        r.st_vld = v[7][0];
        r.st_adr = v[8];
        r.st_dat = v[9];
        r.err    = v[10][0];
        r.stl    = v[11][0];
        exp_rec.push_back(r);
      end
      "V": begin
        void'($sscanf(line, "V %h %h %h", v[0], v[1], v[2]));
        e      = '0;
        e.kind = trace_pkg::evt_kind_t'(v[0][1:0]);
        e.pha  = trace_pkg::pha_t'(v[1][2:0]);
        e.adr  = v[2];
        exp_evt.push_back(e);
      end
      "C": begin
        void'($sscanf(line, "C %s %d %d %d", name, v[0], v[1], v[2]));
        finish_test(name, v[0], v[1][0], v[2][0]);
      end
      default: begin
        $display("stim line not understood: %s", line);
        errors++;
      end
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    bit ok;
    arst_n  = 1'b0;
    tcb_vld = 1'b0;
    tcb_rdy = 1'b0;
    tcb_req = '0;
    tcb_rsp = '0;
    pha     = trace_pkg::pha_if;
    rec_pop = 1'b0;
    evt_pop = 1'b0;
    void'($urandom(32'h6143));
    load_stim(ok);
    if (!ok) begin
      $display("cannot open the stimulus file tb/tcb_trace_stim.txt");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      apply_reset();
      foreach (lines[i]) run_line(lines[i]);
      $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tcb_trace_stim.txt ====
# T pha wen adr siz wdt rdt err gap (hex, gap in cycles) / V kind pha adr / C name retire rovf eovf
# E pc ins wb_vld wb_rd wb_dat ld_vld ld_adr st_vld st_adr st_dat err stl (phase 0 if 1 mld 2 mst 3 exe 4 wb 5 rs1 6 rs2)
T 0 0 00000000 2 00000000 1000006f 0 0
T 0 0 00000100 2 00000000 00a00093 0 0
T 5 0 00000000 2 00000000 00000000 0 0
T 4 1 00000004 2 0000000a 00000000 0 1
T 0 0 00000104 2 00000000 0400a103 0 0
T 5 0 00000004 2 00000000 0000000a 0 0
T 1 0 00001040 2 00000000 deadbeef 0 0
T 4 1 00000008 2 deadbeef 00000000 0 0
T 0 0 00000108 2 00000000 0420a223 0 0
T 5 0 00000004 2 00000000 0000000a 0 0
T 6 0 00000008 2 00000000 deadbeef 0 0
T 2 1 00001044 2 deadbeef 00000000 0 1
T 0 0 0000010c 2 00000000 00000013 0 24
E 00000100 00a00093 1 01 0000000a 0 00000000 0 00000000 00000000 0 0
E 00000104 0400a103 1 02 deadbeef 1 00001040 0 00000000 00000000 0 0
E 00000108 0420a223 0 00 00000000 0 00000000 1 00001044 deadbeef 0 0
E 0000010c 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 1
C basic 4 0 0
T 0 0 00000000 2 00000000 2000006f 0 0
T 0 0 00000200 2 00000000 00208033 0 0
T 5 0 00000004 2 00000000 00000001 0 0
T 6 0 00000008 2 00000000 00000002 0 0
T 3 0 00000000 2 00000000 00000000 0 0
T 4 1 0000000c 0 00000055 00000000 0 0
T 0 0 00000204 2 00000000 00209033 0 0
T 4 1 0000000c 1 00005555 00000000 0 0
T 4 0 0000000c 2 00000000 00000000 0 0
T 0 0 00000208 2 00000000 00208fb3 0 0
T 4 1 0000007c 2 12345678 00000000 0 0
T 0 0 0000020c 2 00000000 00000013 0 24
E 00000200 00208033 0 00 00000000 0 00000000 0 00000000 00000000 0 0
E 00000204 00209033 0 00 00000000 0 00000000 0 00000000 00000000 0 0
E 00000208 00208fb3 1 1f 12345678 0 00000000 0 00000000 00000000 0 0
E 0000020c 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 1
C wb_filter 4 0 0
T 0 0 00000000 2 00000000 3000006f 0 0
T 0 0 00000300 2 00000000 0000a183 0 0
T 5 0 00000004 2 00000000 00002000 0 0
T 1 0 00002000 2 00000000 00000000 1 0
T 4 1 0000000c 2 00000000 00000000 0 0
T 0 0 00000304 2 00000000 00000013 0 24
E 00000300 0000a183 1 03 00000000 1 00002000 0 00000000 00000000 1 0
E 00000304 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 1
V 0 1 00002000
C bus_err 2 0 0
T 1 0 00003000 2 00000000 00000000 0 0
T 0 0 00000000 2 00000000 4000006f 0 0
T 0 0 00000400 2 00000000 0020a023 0 0
T 2 1 00003000 2 11111111 00000000 0 0
T 2 1 00003004 2 22222222 00000000 0 0
T 0 0 00000404 2 00000000 00000013 0 24
E 00000400 0020a023 0 00 00000000 0 00000000 1 00003000 11111111 0 0
E 00000404 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 1
V 1 1 00003000
V 2 2 00003004
C order_err 2 0 0
T 0 0 00000000 2 00000000 5000006f 0 0
T 0 0 00000500 2 00000000 00000013 0 0
T 5 0 00000000 2 00000000 00000000 0 24
T 0 0 00000504 2 00000000 00500293 0 0
T 4 1 00000014 2 00000005 00000000 0 0
T 0 0 00000508 2 00000000 00000013 0 24
E 00000500 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 1
E 00000504 00500293 1 05 00000005 0 00000000 0 00000000 00000000 0 0
E 00000508 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 1
C watchdog 3 0 0
T 0 0 00000000 2 00000000 6000006f 0 0
T 0 0 00000600 2 00000000 00000013 0 0
T 0 0 00000604 2 00000000 00000013 0 0
T 0 0 00000608 2 00000000 00000013 0 0
T 0 0 0000060c 2 00000000 00000013 0 0
T 0 0 00000610 2 00000000 00000013 0 0
T 0 0 00000614 2 00000000 00000013 0 0
T 0 0 00000618 2 00000000 00000013 0 0
T 0 0 0000061c 2 00000000 00000013 0 0
T 0 0 00000620 2 00000000 00000013 0 0
T 0 0 00000624 2 00000000 00000013 0 0
T 0 0 00000628 2 00000000 00000013 0 24
E 00000600 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 0
E 00000604 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 0
E 00000608 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 0
E 0000060c 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 0
E 00000610 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 0
E 00000614 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 0
E 00000618 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 0
E 0000061c 00000013 0 00 00000000 0 00000000 0 00000000 00000000 0 0
C overflow 11 1 0

// ==== all.f ====
source/tcb_pkg.sv
source/trace_pkg.sv
source/tcb_xfer_capture.sv
source/trace_phase_fsm.sv
source/trace_timer.sv
source/trace_fifo.sv
source/tcb_trace_top.sv
tb/tcb_trace_tb.sv
